/* vseq_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector sequencer package with the shared constants, op and unit
// encodings, request structs and op classification helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vseq_pkg;

  // Lanes plus load, store and mask unit
  localparam int unsigned NrLanes     = 2;
  localparam int unsigned NrPEs       = NrLanes + 3;
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;
  localparam int unsigned OffsetMask  = 2;

  // Instructions in flight and architectural registers
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned NrVRegs = 32;

  typedef logic [2:0] vid_t;
  typedef logic [4:0] vreg_t;

  // v0 holds the mask
  localparam vreg_t VMASK = 5'd0;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VXOR,
    VMAND,
    VMOR,
    VLE,
    VSE
  } ara_op_e;

  typedef enum logic [1:0] {
    VFU_Alu,
    VFU_MaskUnit,
    VFU_LoadUnit,
    VFU_StoreUnit
  } vfu_e;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

  // Request from the dispatcher
  typedef struct packed {
    ara_op_e     op;
    vreg_t       vs1;
    logic        use_vs1;
    vreg_t       vs2;
    logic        use_vs2;
    vreg_t       vd;
    logic        use_vd;
    logic        vm;
    logic [31:0] scalar_op;
    eew_e        eew;
    logic [3:0]  vl;
  } vseq_req_t;

  // Broadcast to the processing elements, hazards one bit per id
  typedef struct packed {
    vid_t               id;
    ara_op_e            op;
    vfu_e               vfu;
    logic               vm;
    logic [3:0]         vl;
    logic [31:0]        scalar_op;
    eew_e               eew;
    logic [NrVInsn-1:0] hazard_vs1;
    logic [NrVInsn-1:0] hazard_vs2;
    logic [NrVInsn-1:0] hazard_vd;
    logic [NrVInsn-1:0] hazard_vm;
  } pe_req_t;

  function automatic logic is_load(ara_op_e op);
    return op == VLE;
  endfunction

  function automatic logic is_store(ara_op_e op);
    return op == VSE;
  endfunction

  // Unit that executes an op
  function automatic vfu_e vfu_of(ara_op_e op);
    case (op)
      VMAND, VMOR: return VFU_MaskUnit;
      VLE:         return VFU_LoadUnit;
      VSE:         return VFU_StoreUnit;
      default:     return VFU_Alu;
    endcase
  endfunction

endpackage

`default_nettype wire

/* vseq_pe_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer to processing element link: request broadcast, ready, done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface vseq_pe_if;
  import vseq_pkg::*;

  pe_req_t pe_req;
  logic    pe_req_valid;

  // Each element drives its own bit and row
  wire [NrPEs-1:0]              pe_ready;
  wire [NrPEs-1:0][NrVInsn-1:0] pe_done;

  // Completions of this cycle from any element
  logic [NrVInsn-1:0] done_all;

  always_comb begin
    done_all = '0;
    for (int p = 0; p < NrPEs; p++) begin
      done_all = done_all | pe_done[p];
    end
  end

  modport seq_mp (output pe_req, output pe_req_valid, input pe_ready, input pe_done,
                  input done_all);
  modport pe_mp (input pe_req, input pe_req_valid, input done_all, output pe_ready,
                 output pe_done);

endinterface

`default_nettype wire

/* vseq_addrgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address generator model, acknowledges loads and stores with an
// alignment check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vseq_addrgen (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  vseq_pkg::pe_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              addrgen_ack_o,
  output logic              addrgen_error_o
);
  import vseq_pkg::*;

  logic       is_mem;
  logic       misaligned;
  logic       pending_q;
  logic [1:0] cnt_q;
  logic       ack_q;
  logic       err_q;

  assign is_mem = pe_req_valid_i && (is_load(pe_req_i.op) || is_store(pe_req_i.op));

  // Address must be a multiple of the element size in bytes
  always_comb begin
    case (pe_req_i.eew)
      EW8:     misaligned = 1'b0;
      EW16:    misaligned = pe_req_i.scalar_op[0];
      EW32:    misaligned = |pe_req_i.scalar_op[1:0];
      default: misaligned = |pe_req_i.scalar_op[2:0];
    endcase
  end

  // Ack lands three cycles after the broadcast
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (is_mem) begin
        pending_q <= 1'b1;
        cnt_q     <= 2'd2;
        err_q     <= misaligned;
      end else if (pending_q) begin
        if (cnt_q == 2'd1) begin
          pending_q <= 1'b0;
          ack_q     <= 1'b1;
        end
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  assign addrgen_ack_o   = ack_q;
  assign addrgen_error_o = err_q;

endmodule

`default_nettype wire

/* vseq_exec_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processing element model holding one instruction until its hazards
// clear, then running for vl cycles and signalling completion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vseq_exec_unit #(
  parameter int unsigned PE_IDX = 0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  vseq_pe_if.pe_mp  pe
);
  import vseq_pkg::*;

  vfu_e unit;
  logic is_mask_pe;
  logic take;
  logic hazard_clear;

  logic               busy_q;
  vid_t               id_q;
  logic [3:0]         cnt_q;
  logic [NrVInsn-1:0] haz_vs1_q;
  logic [NrVInsn-1:0] haz_vs2_q;
  logic [NrVInsn-1:0] haz_vd_q;
  logic [NrVInsn-1:0] haz_vm_q;
  logic [NrVInsn-1:0] done_q;

  // Lanes first, then load, store and mask unit
  always_comb begin
    if (PE_IDX < NrLanes)
      unit = VFU_Alu;
    else if (PE_IDX == NrLanes + OffsetLoad)
      unit = VFU_LoadUnit;
    else if (PE_IDX == NrLanes + OffsetStore)
      unit = VFU_StoreUnit;
    else
      unit = VFU_MaskUnit;
  end

  assign is_mask_pe = (unit == VFU_MaskUnit);

  // Mask unit also serves every masked instruction
  assign take = pe.pe_req_valid &&
                ((pe.pe_req.vfu == unit) || (is_mask_pe && !pe.pe_req.vm));

  assign hazard_clear = ~|{haz_vs1_q, haz_vs2_q, haz_vd_q, haz_vm_q};

  // Not ready while occupied, nor in the cycle a request is taken
  assign pe.pe_ready[PE_IDX] = !busy_q && !take;
  assign pe.pe_done[PE_IDX]  = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      haz_vs1_q <= '0;
      haz_vs2_q <= '0;
      haz_vd_q  <= '0;
      haz_vm_q  <= '0;
      done_q    <= '0;
    end else begin
      done_q <= '0;
      if (take) begin
        busy_q    <= 1'b1;
        cnt_q     <= pe.pe_req.vl;
        // Completions seen in the latch cycle count too
        haz_vs1_q <= pe.pe_req.hazard_vs1 & ~pe.done_all;
        haz_vs2_q <= pe.pe_req.hazard_vs2 & ~pe.done_all;
        haz_vd_q  <= pe.pe_req.hazard_vd & ~pe.done_all;
        haz_vm_q  <= pe.pe_req.hazard_vm & ~pe.done_all;
      end else if (busy_q) begin
        haz_vs1_q <= haz_vs1_q & ~pe.done_all;
        haz_vs2_q <= haz_vs2_q & ~pe.done_all;
        haz_vd_q  <= haz_vd_q & ~pe.done_all;
        haz_vm_q  <= haz_vm_q & ~pe.done_all;
        if (hazard_clear) begin
          // Last beat: pulse done and free the slot together
          if (cnt_q <= 4'd1) begin
            busy_q       <= 1'b0;
            done_q[id_q] <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 4'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take)
      id_q <= pe.pe_req.id;
  end

endmodule

`default_nettype wire

/* vseq_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order vector sequencer: id allocation, hazard tracking, issue to
// the processing elements and load/store response handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vseq_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vseq_pkg::vseq_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output logic                resp_valid_o,
  output logic                resp_error_o,
  output logic                idle_o,
  input  logic                addrgen_ack_i,
  input  logic                addrgen_error_i,
  vseq_pe_if.seq_mp           pe
);
  import vseq_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } seq_state_e;

  // Last reader or writer of a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  seq_state_e state_d, state_q;

  // Row per element, bit per instruction id
  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_d, pe_running_q;
  logic [NrVInsn-1:0]            running;
  logic [NrVInsn-1:0]            running_next;

  vid_t next_id;
  logic id_full;
  logic struct_hazard;
  logic accept;

  vreg_access_t [NrVRegs-1:0] read_list_d, read_list_q;
  vreg_access_t [NrVRegs-1:0] write_list_d, write_list_q;

  pe_req_t pe_req_d;
  logic    pe_req_valid_d;

  // Running set now, and without the ids completing this cycle
  always_comb begin
    running      = '0;
    running_next = '0;
    for (int p = 0; p < NrPEs; p++) begin
      running      = running | pe_running_q[p];
      running_next = running_next | (pe_running_q[p] & ~pe.pe_done[p]);
    end
  end

  assign idle_o = ~|running;

  // Lowest free id, scan from the top so bit 0 wins
  always_comb begin
    next_id = '0;
    id_full = 1'b1;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running[i]) begin
        next_id = vid_t'(i);
        id_full = 1'b0;
      end
    end
  end

  // Store unit and mask unit share one queue
  always_comb begin
    struct_hazard = 1'b0;
    case (vfu_of(req_i.op))
      VFU_StoreUnit: struct_hazard = |pe_running_q[NrLanes + OffsetMask];
      VFU_MaskUnit:  struct_hazard = |pe_running_q[NrLanes + OffsetStore];
      default:       struct_hazard = 1'b0;
    endcase
  end

  assign req_ready_o = (state_q == IDLE) && (&pe.pe_ready) && !struct_hazard && !id_full;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    state_d        = state_q;
    pe_running_d   = pe_running_q;
    read_list_d    = read_list_q;
    write_list_d   = write_list_q;
    pe_req_d       = pe.pe_req;
    pe_req_valid_d = 1'b0;
    resp_valid_o   = 1'b0;
    resp_error_o   = 1'b0;

    // Drop access entries whose instruction has finished
    for (int v = 0; v < NrVRegs; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running[write_list_q[v].vid];
    end

    // Retire per element on its done row
    for (int p = 0; p < NrPEs; p++) begin
      pe_running_d[p] = pe_running_q[p] & ~pe.pe_done[p];
    end

    case (state_q)
      IDLE: begin
        if (accept) begin
          case (vfu_of(req_i.op))
            VFU_LoadUnit:  pe_running_d[NrLanes + OffsetLoad][next_id] = 1'b1;
            VFU_StoreUnit: pe_running_d[NrLanes + OffsetStore][next_id] = 1'b1;
            VFU_MaskUnit:  pe_running_d[NrLanes + OffsetMask][next_id] = 1'b1;
            default: begin
              for (int l = 0; l < NrLanes; l++) begin
                pe_running_d[l][next_id] = 1'b1;
              end
            end
          endcase
          // Masked ops also occupy the mask unit
          if (!req_i.vm) begin
            pe_running_d[NrLanes + OffsetMask][next_id] = 1'b1;
          end

          pe_req_d = '{
            id:        next_id,
            op:        req_i.op,
            vfu:       vfu_of(req_i.op),
            vm:        req_i.vm,
            vl:        req_i.vl,
            scalar_op: req_i.scalar_op,
            eew:       req_i.eew,
            default:   '0
          };
          pe_req_valid_d = 1'b1;

          // RAW on sources and mask
          if (req_i.use_vs1 && write_list_d[req_i.vs1].valid)
            pe_req_d.hazard_vs1[write_list_d[req_i.vs1].vid] = 1'b1;
          if (req_i.use_vs2 && write_list_d[req_i.vs2].valid)
            pe_req_d.hazard_vs2[write_list_d[req_i.vs2].vid] = 1'b1;
          if (!req_i.vm && write_list_d[VMASK].valid)
            pe_req_d.hazard_vm[write_list_d[VMASK].vid] = 1'b1;
          // WAR then WAW on the destination
          if (req_i.use_vd && read_list_d[req_i.vd].valid)
            pe_req_d.hazard_vd[read_list_d[req_i.vd].vid] = 1'b1;
          if (req_i.use_vd && write_list_d[req_i.vd].valid)
            pe_req_d.hazard_vd[write_list_d[req_i.vd].vid] = 1'b1;

          // Record the new accesses after the lookups
          if (req_i.use_vd)
            write_list_d[req_i.vd] = '{vid: next_id, valid: 1'b1};
          if (req_i.use_vs1)
            read_list_d[req_i.vs1] = '{vid: next_id, valid: 1'b1};
          if (req_i.use_vs2)
            read_list_d[req_i.vs2] = '{vid: next_id, valid: 1'b1};
          if (!req_i.vm)
            read_list_d[VMASK] = '{vid: next_id, valid: 1'b1};

          // Memory ops block until the address generator answers
          if (is_load(req_i.op) || is_store(req_i.op))
            state_d = WAIT;
        end
      end
      WAIT: begin
        if (addrgen_ack_i) begin
          state_d      = IDLE;
          resp_valid_o = 1'b1;
          resp_error_o = addrgen_error_i;
        end
      end
      default: state_d = IDLE;
    endcase

    // Ids finishing this cycle are no hazard any more
    pe_req_d.hazard_vs1 = pe_req_d.hazard_vs1 & running_next;
    pe_req_d.hazard_vs2 = pe_req_d.hazard_vs2 & running_next;
    pe_req_d.hazard_vd  = pe_req_d.hazard_vd & running_next;
    pe_req_d.hazard_vm  = pe_req_d.hazard_vm & running_next;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= IDLE;
      pe_running_q     <= '0;
      read_list_q      <= '0;
      write_list_q     <= '0;
      pe.pe_req_valid  <= 1'b0;
    end else begin
      state_q          <= state_d;
      pe_running_q     <= pe_running_d;
      read_list_q      <= read_list_d;
      write_list_q     <= write_list_d;
      pe.pe_req_valid  <= pe_req_valid_d;
    end
  end

  // Broadcast payload, qualified by pe_req_valid
  always_ff @(posedge clk_i) begin
    pe.pe_req <= pe_req_d;
  end

endmodule

`default_nettype wire

/* vseq_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector sequencer subsystem top with two lanes, load, store and mask
// units and the address generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vseq_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  vseq_pkg::vseq_req_t            req_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  output logic                           resp_valid_o,
  output logic                           resp_error_o,
  output logic                           idle_o,
  output logic [vseq_pkg::NrVInsn-1:0]   done_o
);
  import vseq_pkg::*;

  logic addrgen_ack;
  logic addrgen_error;

  vseq_pe_if u_pe_if ();

  vseq_sequencer u_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_error_o   (resp_error_o),
    .idle_o         (idle_o),
    .addrgen_ack_i  (addrgen_ack),
    .addrgen_error_i(addrgen_error),
    .pe             (u_pe_if.seq_mp)
  );

  // Snoops the broadcast for memory ops
  vseq_addrgen u_addrgen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (u_pe_if.pe_req),
    .pe_req_valid_i (u_pe_if.pe_req_valid),
    .addrgen_ack_o  (addrgen_ack),
    .addrgen_error_o(addrgen_error)
  );

  // Lanes, then load, store and mask unit
  for (genvar p = 0; p < NrPEs; p++) begin : gen_pe
    vseq_exec_unit #(
      .PE_IDX(p)
    ) u_pe (
      .clk_i (clk_i),
      .rst_ni(rst_ni),
      .pe    (u_pe_if.pe_mp)
    );
  end

  assign done_o = u_pe_if.done_all;

endmodule

`default_nettype wire

/* tb_vseq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the vector sequencer subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_vseq;
  import vseq_pkg::*;

  // Eighteen requests plus reset and drain, at most 100 cycles each
  localparam int unsigned NrReqs         = 18;
  localparam int unsigned WatchdogCycles = (NrReqs + 2) * 100;
  localparam int unsigned WaitLimit      = 100;

  logic               clk_i;
  logic               rst_ni;
  vseq_req_t          req_i;
  logic               req_valid_i;
  logic               req_ready_o;
  logic               resp_valid_o;
  logic               resp_error_o;
  logic               idle_o;
  logic [NrVInsn-1:0] done_o;

  // Reference model, owned by the falling edge monitor
  logic [NrVInsn-1:0] model_run;
  vid_t               exp_ids[$];
  int unsigned        cyc;
  int unsigned        acc_cnt;
  int unsigned        resp_cnt;
  int unsigned        last_acc;
  vid_t               last_id;
  logic               last_err;
  int unsigned        done_stamp[NrVInsn];
  logic               mem_wait;
  logic               mem_err;
  int unsigned        mem_acc;

  int unsigned        err_cnt;
  logic [15:0]        lfsr_q;
  string              test_name;

  vseq_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .resp_valid_o(resp_valid_o),
    .resp_error_o(resp_error_o),
    .idle_o      (idle_o),
    .done_o      (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("Mismatch [%s] %s: expected 0x%0h, actual 0x%0h",
                          test_name, name, exp, act));
    end
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic vid_t lowest_free(input logic [NrVInsn-1:0] run);
    for (int i = 0; i < NrVInsn; i++) begin
      if (!run[i])
        return vid_t'(i);
    end
    return '0;
  endfunction

  // Address must be a whole number of elements
  function automatic logic misaligned(input logic [31:0] addr, input eew_e eew);
    return (addr % (32'd1 << eew)) != 32'd0;
  endfunction

  function automatic vseq_req_t make_req(input ara_op_e op, input vreg_t vs1, input logic u1,
                                         input vreg_t vs2, input logic u2, input vreg_t vd,
                                         input logic ud, input logic vm,
                                         input logic [31:0] addr, input eew_e eew,
                                         input logic [3:0] vl);
    vseq_req_t r;
    r.op        = op;
    r.vs1       = vs1;
    r.use_vs1   = u1;
    r.vs2       = vs2;
    r.use_vs2   = u2;
    r.vd        = vd;
    r.use_vd    = ud;
    r.vm        = vm;
    r.scalar_op = addr;
    r.eew       = eew;
    r.vl        = vl;
    return r;
  endfunction

  // Tracks ids, completions and responses once per cycle
  always @(negedge clk_i) begin
    logic [NrVInsn-1:0] onehot;
    vid_t               id;
    logic               accepted;
    if (!rst_ni) begin
      model_run = '0;
      exp_ids.delete();
      cyc       = 0;
      acc_cnt   = 0;
      resp_cnt  = 0;
      last_acc  = 0;
      last_id   = '0;
      last_err  = 1'b0;
      mem_wait  = 1'b0;
      mem_err   = 1'b0;
      mem_acc   = 0;
      for (int i = 0; i < NrVInsn; i++) begin
        done_stamp[i] = 0;
      end
    end else begin
      cyc++;
      id       = '0;
      accepted = req_valid_i && req_ready_o;
      check("idle_o against running ids", 32'(model_run == '0), 32'(idle_o));
      // In-order completion, one id per pulse
      if (done_o != '0) begin
        if (exp_ids.size() == 0)
          abort_run("A done pulse arrived with no instruction in flight");
        onehot             = '0;
        onehot[exp_ids[0]] = 1'b1;
        check("done id", 32'(onehot), 32'(done_o));
        done_stamp[exp_ids[0]] = cyc;
        void'(exp_ids.pop_front());
      end
      if (resp_valid_o) begin
        if (!mem_wait)
          abort_run("A response arrived with no load or store waiting");
        check("response error", 32'(mem_err), 32'(resp_error_o));
        // Broadcast one cycle after acceptance, ack three cycles later
        check("response delay", 32'd4, cyc - mem_acc);
        mem_wait = 1'b0;
        last_err = resp_error_o;
        resp_cnt++;
      end else if (mem_wait && req_ready_o) begin
        abort_run("req_ready_o went high while a load or store waited for its response");
      end
      // Ids retiring this cycle are still taken
      if (accepted) begin
        id = lowest_free(model_run);
        exp_ids.push_back(id);
        last_id  = id;
        last_acc = cyc;
        acc_cnt++;
        if (req_i.op == VLE || req_i.op == VSE) begin
          mem_wait = 1'b1;
          mem_err  = misaligned(req_i.scalar_op, req_i.eew);
          mem_acc  = cyc;
        end
      end
      model_run = model_run & ~done_o;
      if (accepted)
        model_run[id] = 1'b1;
    end
  end

  // Holds the request until accepted, returns with valid low
  task automatic send_req(input vseq_req_t r, output vid_t id, output int unsigned acc);
    int unsigned prior;
    int unsigned n;
    prior       = acc_cnt;
    n           = 0;
    req_i       = r;
    req_valid_i = 1'b1;
    while (acc_cnt == prior) begin
      @(posedge clk_i);
      #1;
      n++;
      if (acc_cnt == prior && n > WaitLimit)
        abort_run($sformatf("[%s] request was not accepted in time", test_name));
    end
    req_valid_i = 1'b0;
    id          = last_id;
    acc         = last_acc;
  endtask

  task automatic wait_done(input vid_t id, input int unsigned since, output int unsigned at);
    int unsigned n;
    n = 0;
    while (done_stamp[id] <= since) begin
      @(posedge clk_i);
      #1;
      n++;
      if (done_stamp[id] <= since && n > WaitLimit)
        abort_run($sformatf("[%s] no done pulse for id %0d in time", test_name, id));
    end
    at = done_stamp[id];
  endtask

  task automatic wait_resp(input int unsigned count);
    int unsigned n;
    n = 0;
    while (resp_cnt < count) begin
      @(posedge clk_i);
      #1;
      n++;
      if (resp_cnt < count && n > WaitLimit)
        abort_run($sformatf("[%s] load or store response never came", test_name));
    end
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (model_run != '0 || exp_ids.size() != 0) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 4 * WaitLimit)
        abort_run($sformatf("[%s] instructions did not drain", test_name));
    end
    @(negedge clk_i);
    check("idle_o after drain", 32'd1, 32'(idle_o));
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_reset_state();
    test_name = "reset";
    @(negedge clk_i);
    check("idle_o", 32'd1, 32'(idle_o));
    check("req_ready_o", 32'd1, 32'(req_ready_o));
    check("resp_valid_o", 32'd0, 32'(resp_valid_o));
    check("done_o", 32'd0, 32'(done_o));
    @(posedge clk_i);
    #1;
  endtask

  // Back to back, each accepted in the cycle its predecessor retires
  task automatic test_id_alloc();
    vid_t        ids[3];
    int unsigned acc[3];
    int unsigned at;
    test_name = "id_alloc";
    for (int i = 0; i < 3; i++) begin
      send_req(make_req(ara_op_e'(i), vreg_t'(3 * i + 1), 1'b1, vreg_t'(3 * i + 2), 1'b1,
                        vreg_t'(3 * i + 3), 1'b1, 1'b1, '0, EW32, 4'd15), ids[i], acc[i]);
    end
    check("first id", 32'd0, 32'(ids[0]));
    check("second id while id 0 retires", 32'd1, 32'(ids[1]));
    check("third id after id 0 freed", 32'd0, 32'(ids[2]));
    // Broadcast, then vl counting cycles, then the pulse
    wait_done(ids[1], acc[1], at);
    check("latency of second", 32'd17, at - acc[1]);
    wait_done(ids[2], acc[2], at);
    check("latency of third", 32'd17, at - acc[2]);
    wait_idle();
  endtask

  task automatic test_raw();
    vid_t        id_a;
    vid_t        id_b;
    int unsigned acc_a;
    int unsigned acc_b;
    int unsigned done_b;
    test_name = "raw";
    send_req(make_req(VADD, 5'd1, 1'b1, 5'd2, 1'b1, 5'd3, 1'b1, 1'b1, '0, EW32, 4'd15),
             id_a, acc_a);
    send_req(make_req(VXOR, 5'd3, 1'b1, 5'd4, 1'b1, 5'd5, 1'b1, 1'b1, '0, EW32, 4'd1),
             id_b, acc_b);
    wait_done(id_b, acc_b, done_b);
    check("producer latency", 32'd17, done_stamp[id_a] - acc_a);
    check("consumer done after producer", 32'd1, 32'(done_b > done_stamp[id_a]));
    wait_idle();
  endtask

  task automatic test_load_resp();
    vid_t        id;
    int unsigned acc;
    int unsigned start;
    test_name = "load_resp";
    start     = resp_cnt;
    send_req(make_req(VLE, '0, 1'b0, '0, 1'b0, 5'd6, 1'b1, 1'b1, 32'h1000, EW32, 4'd2),
             id, acc);
    wait_resp(start + 1);
    check("aligned load error", 32'd0, 32'(last_err));
    send_req(make_req(VLE, '0, 1'b0, '0, 1'b0, 5'd6, 1'b1, 1'b1, 32'h1002, EW32, 4'd2),
             id, acc);
    wait_resp(start + 2);
    check("misaligned load error", 32'd1, 32'(last_err));
    wait_idle();
    check("response count", 32'd2, resp_cnt - start);
  endtask

  // Store waits for the mask unit to retire its instruction
  task automatic test_struct_hazard();
    vid_t        id_m;
    vid_t        id_s;
    int unsigned acc_m;
    int unsigned acc_s;
    int unsigned start;
    test_name = "struct_hazard";
    start     = resp_cnt;
    send_req(make_req(VMAND, 5'd9, 1'b1, 5'd10, 1'b1, 5'd8, 1'b1, 1'b1, '0, EW8, 4'd15),
             id_m, acc_m);
    send_req(make_req(VSE, 5'd11, 1'b1, '0, 1'b0, '0, 1'b0, 1'b1, 32'h2000, EW64, 4'd3),
             id_s, acc_s);
    check("mask op done before store issue", 32'd1, 32'(done_stamp[id_m] > acc_m));
    check("store accept cycle", done_stamp[id_m] + 1, acc_s);
    wait_resp(start + 1);
    check("store error", 32'd0, 32'(last_err));
    wait_idle();
  endtask

  // Nine ops in a row, each taken only in the cycle its predecessor retires
  task automatic test_id_reuse();
    logic [31:0] r;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] d;
    logic [31:0] m;
    logic [31:0] l;
    vid_t        id;
    vid_t        prev_id;
    int unsigned acc;
    test_name = "id_reuse";
    prev_id   = '0;
    for (int i = 0; i < 9; i++) begin
      rand_bits(2, r);
      rand_bits(5, s1);
      rand_bits(5, s2);
      rand_bits(5, d);
      rand_bits(1, m);
      rand_bits(3, l);
      send_req(make_req(ara_op_e'(3'(r % 32'd3)), s1[4:0], 1'b1, s2[4:0], 1'b1, d[4:0],
                        1'b1, m[0], '0, EW16, {1'b0, l[2:0]} + 4'd1), id, acc);
      if (i > 0)
        check("accept at predecessor retire", done_stamp[prev_id], acc);
      prev_id = id;
    end
    wait_idle();
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    abort_run("The watchdog expired before the tests finished");
  end

  initial begin
    err_cnt     = 0;
    lfsr_q      = 16'd8728;
    test_name   = "init";
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_state();
    test_id_alloc();
    test_raw();
    test_load_resp();
    test_struct_hazard();
    test_id_reuse();
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
vseq_pkg.sv
vseq_pe_if.sv
vseq_addrgen.sv
vseq_exec_unit.sv
vseq_sequencer.sv
vseq_top.sv
tb_vseq.sv

/* run.sh */
#!/usr/bin/env bash
# Build the vector sequencer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_vseq -f list.f -o sim_vseq

if ./obj_dir/sim_vseq | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
